// File: verilog/rename_params.svh
`ifndef RENAME_PARAMS_SVH
`define RENAME_PARAMS_SVH

// architectural and physical register file sizes
`define ARCH_REGS      32
`define PHYS_REGS      64
`define ARCH_REG_BITS  5
`define PHYS_REG_BITS  6

// result broadcasts per cycle
`define CDB_PORTS      2

// registers not covered by the committed map
`define FREE_REGS      (`PHYS_REGS - `ARCH_REGS)

`endif

// File: verilog/rv32i_pkg.sv
`default_nettype none

package rv32i_pkg;

    // major opcodes that the rename stage distinguishes
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv_opcode_e;

    // register-field layout
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_r_view_t;

    // upper-immediate layout, also covers jal
    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_u_view_t;

    typedef union packed {
        rv_r_view_t r;
        rv_u_view_t u;
    } rv_inst_u;

endpackage

`default_nettype wire

// File: verilog/rename_pkg.sv
`include "rename_params.svh"

`default_nettype none

package rename_pkg;
    import rv32i_pkg::*;

    typedef logic [`PHYS_REG_BITS-1:0] phys_tag_t;

    // decoded instruction entering rename
    typedef struct packed {
        rv_inst_u    inst;
        logic [31:0] pc;
    } dispatch_t;

    // instruction leaving rename with physical tags
    typedef struct packed {
        rv_inst_u                 inst;
        logic [31:0]              pc;
        phys_tag_t                ps1;
        phys_tag_t                ps2;
        phys_tag_t                pd;
        logic                     ps1_ready;
        logic                     ps2_ready;
        logic                     has_rd;
        logic [`ARCH_REG_BITS-1:0] rd;
    } renamed_t;

    // one result broadcast
    typedef struct packed {
        logic                      valid;
        logic [`ARCH_REG_BITS-1:0] rd;
        phys_tag_t                 pd;
    } cdb_t;

    // in-order retirement from the ROB
    typedef struct packed {
        logic                      valid;
        logic [`ARCH_REG_BITS-1:0] rd;
        phys_tag_t                 pd;
    } commit_t;

endpackage

`default_nettype wire

// File: verilog/rat.sv
`include "rename_params.svh"

`default_nettype none

module rat
    import rename_pkg::*;
(
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic [`ARCH_REG_BITS-1:0] rs1,
    input  wire logic [`ARCH_REG_BITS-1:0] rs2,
    output phys_tag_t                      ps1,
    output phys_tag_t                      ps2,
    output logic                           ps1_ready,
    output logic                           ps2_ready,
    input  wire logic                      rename_we,
    input  wire logic [`ARCH_REG_BITS-1:0] rename_rd,
    input  phys_tag_t                      rename_pd,
    input  cdb_t                           cdb [`CDB_PORTS],
    input  wire logic                      flush,
    input  phys_tag_t                      restore_map [`ARCH_REGS]
);

    phys_tag_t              map_q [`ARCH_REGS];
    phys_tag_t              map_d [`ARCH_REGS];
    logic [`ARCH_REGS-1:0]  ready_q;
    logic [`ARCH_REGS-1:0]  ready_d;

    // lookups see the state before this edge, no bypass
    assign ps1       = map_q[rs1];
    assign ps2       = map_q[rs2];
    assign ps1_ready = ready_q[rs1];
    assign ps2_ready = ready_q[rs2];

    always_comb begin
        map_d   = map_q;
        ready_d = ready_q;

        // wakeup only if rd still points at the broadcast tag
        for (int p = 0; p < `CDB_PORTS; p++) begin
            if (cdb[p].valid && cdb[p].pd == map_q[cdb[p].rd]) begin
                ready_d[cdb[p].rd] = 1'b1;
            end
        end

        // new mapping wins over a same-cycle wakeup of the old tag
        if (rename_we && rename_rd != '0) begin
            map_d[rename_rd]   = rename_pd;
            ready_d[rename_rd] = 1'b0;
        end

        ready_d[0] = 1'b1;

        // restore committed state, all values are architectural
        if (flush) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map_d[i]   = restore_map[i];
                ready_d[i] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map_q[i] <= phys_tag_t'(i);
            end
            ready_q <= '1;
        end else begin
            map_q   <= map_d;
            ready_q <= ready_d;
        end
    end

    // x0 survives renames and flush restores
    a_map0_zero: assert property (
        @(posedge clk) disable iff (rst) map_q[0] == '0
    ) else $error("MISMATCH rat map_q[0] = 0x%0h", map_q[0]);

    // top level must hold off dispatch during flush
    a_no_rename_on_flush: assert property (
        @(posedge clk) disable iff (rst) !(rename_we && flush)
    ) else $error("MISMATCH rat rename_we with flush, rd 0x%0h", rename_rd);

endmodule

`default_nettype wire

// File: verilog/rrat.sv
`include "rename_params.svh"

`default_nettype none

module rrat
    import rename_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    input  commit_t   commit,
    input  wire logic flush,
    output phys_tag_t arch_map [`ARCH_REGS],
    output logic      free_valid,
    output phys_tag_t free_pd
);

    logic commit_we;

    assign commit_we = commit.valid && commit.rd != '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                arch_map[i] <= phys_tag_t'(i);
            end
            free_valid <= 1'b0;
        end else begin
            if (commit_we) begin
                arch_map[commit.rd] <= commit.pd;
            end
            free_valid <= commit_we;
        end
    end

    // stale tag leaves with the strobe
    always_ff @(posedge clk) begin
        if (commit_we) begin
            free_pd <= arch_map[commit.rd];
        end
    end

    a_no_commit_x0: assert property (
        @(posedge clk) disable iff (rst) !(commit.valid && commit.rd == '0)
    ) else $error("MISMATCH rrat commit.rd = 0x%0h pd = 0x%0h", commit.rd, commit.pd);

    // flush restore reads arch_map as of this edge
    a_no_commit_on_flush: assert property (
        @(posedge clk) disable iff (rst) !(commit.valid && flush)
    ) else $error("MISMATCH rrat commit with flush, rd = 0x%0h", commit.rd);

endmodule

`default_nettype wire

// File: verilog/free_list.sv
`include "rename_params.svh"

`default_nettype none

module free_list
    import rename_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic flush,
    input  wire logic pop,
    input  wire logic push,
    input  phys_tag_t push_pd,
    output logic      head_valid,
    output phys_tag_t head_pd
);

    localparam int PTR_BITS = $clog2(`FREE_REGS);
    localparam int CNT_BITS = $clog2(`FREE_REGS + 1);

    phys_tag_t           slots [`FREE_REGS];
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS-1:0] wr_ptr;
    logic [CNT_BITS-1:0] count;

    assign head_valid = count != '0;
    assign head_pd    = slots[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `FREE_REGS; i++) begin
                slots[i] <= phys_tag_t'(`ARCH_REGS + i);
            end
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= CNT_BITS'(`FREE_REGS);
        end else begin
            if (push) begin
                slots[wr_ptr] <= push_pd;
                wr_ptr        <= wr_ptr + PTR_BITS'(1);
            end

            if (flush) begin
                // the FREE_REGS slots behind the write pointer are
                // exactly the tags the committed map does not hold
                rd_ptr <= wr_ptr + PTR_BITS'(push);
                count  <= CNT_BITS'(`FREE_REGS);
            end else begin
                if (pop) begin
                    rd_ptr <= rd_ptr + PTR_BITS'(1);
                end
                case ({push, pop})
                    2'b10:   count <= count + CNT_BITS'(1);
                    2'b01:   count <= count - CNT_BITS'(1);
                    default: count <= count;
                endcase
            end
        end
    end

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (rst) pop |-> count != '0
    ) else $error("MISMATCH free_list pop on empty, rd_ptr = 0x%0h", rd_ptr);

    // a full list means nothing speculative is live to retire
    a_no_push_full: assert property (
        @(posedge clk) disable iff (rst) push |-> count != CNT_BITS'(`FREE_REGS)
    ) else $error("MISMATCH free_list push on full, push_pd = 0x%0h", push_pd);

endmodule

`default_nettype wire

// File: verilog/rename_stage.sv
`include "rename_params.svh"

`default_nettype none

module rename_stage
    import rv32i_pkg::*;
    import rename_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic dispatch_valid,
    input  dispatch_t dispatch,
    output logic      dispatch_ready,
    output logic      out_valid,
    output renamed_t  out,
    input  wire logic out_ready,
    input  cdb_t      cdb [`CDB_PORTS],
    input  commit_t   commit,
    input  wire logic flush
);

    rv_inst_u  inst;
    logic      use_rs1;
    logic      use_rs2;
    logic      has_rd;
    logic      out_free;
    logic      accept;
    logic      rename_we;
    phys_tag_t rat_ps1;
    phys_tag_t rat_ps2;
    logic      rat_ps1_ready;
    logic      rat_ps2_ready;
    logic      head_valid;
    phys_tag_t head_pd;
    logic      free_valid;
    phys_tag_t free_pd;
    phys_tag_t arch_map [`ARCH_REGS];
    renamed_t  renamed_d;

    assign inst = dispatch.inst;

    // u-type and jal carry an immediate where rs1 would be
    assign use_rs1 = !(inst.u.opcode inside {op_lui, op_auipc, op_jal});
    assign use_rs2 = inst.r.opcode inside {op_reg, op_br, op_store};
    assign has_rd  = !(inst.r.opcode inside {op_store, op_br}) && inst.r.rd != '0;

    assign out_free       = !out_valid || out_ready;
    assign dispatch_ready = out_free && (head_valid || !has_rd) && !flush;
    assign accept         = dispatch_valid && dispatch_ready;
    assign rename_we      = accept && has_rd;

    always_comb begin
        renamed_d.inst      = dispatch.inst;
        renamed_d.pc        = dispatch.pc;
        renamed_d.ps1       = use_rs1 ? rat_ps1 : '0;
        renamed_d.ps2       = use_rs2 ? rat_ps2 : '0;
        renamed_d.ps1_ready = use_rs1 ? rat_ps1_ready : 1'b1;
        renamed_d.ps2_ready = use_rs2 ? rat_ps2_ready : 1'b1;
        renamed_d.pd        = has_rd ? head_pd : '0;
        renamed_d.has_rd    = has_rd;
        renamed_d.rd        = inst.r.rd;
    end

    // flush squashes whatever sits in the output register
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            out_valid <= 1'b0;
        end else if (out_free) begin
            out_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out <= renamed_d;
        end
    end

    rat u_rat (
        .clk         (clk),
        .rst         (rst),
        .rs1         (inst.r.rs1),
        .rs2         (inst.r.rs2),
        .ps1         (rat_ps1),
        .ps2         (rat_ps2),
        .ps1_ready   (rat_ps1_ready),
        .ps2_ready   (rat_ps2_ready),
        .rename_we   (rename_we),
        .rename_rd   (inst.r.rd),
        .rename_pd   (head_pd),
        .cdb         (cdb),
        .flush       (flush),
        .restore_map (arch_map)
    );

    rrat u_rrat (
        .clk        (clk),
        .rst        (rst),
        .commit     (commit),
        .flush      (flush),
        .arch_map   (arch_map),
        .free_valid (free_valid),
        .free_pd    (free_pd)
    );

    free_list u_free_list (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .pop        (rename_we),
        .push       (free_valid),
        .push_pd    (free_pd),
        .head_valid (head_valid),
        .head_pd    (head_pd)
    );

    a_out_stable: assert property (
        @(posedge clk) disable iff (rst)
        (out_valid && !out_ready && !flush) |=> (out_valid && $stable(out))
    ) else $error("MISMATCH rename_stage out changed while stalled, pd = 0x%0h", out.pd);

endmodule

`default_nettype wire

// File: dv/rename_tb.sv
`include "rename_params.svh"

`default_nettype none

module rename_tb
    import rv32i_pkg::*;
    import rename_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD    = 10;
    localparam int RESET_CYCLES  = 3;
    localparam int RANDOM_CYCLES = 300;
    localparam int FILL_CYCLES   = 40;
    localparam int IDLE_CYCLES   = 5;
    // two flush cycles and the reset release
    localparam int TOTAL_CYCLES  = RESET_CYCLES + 2 * RANDOM_CYCLES + FILL_CYCLES
                                   + IDLE_CYCLES + 3;
    localparam int MARGIN        = 3;
    localparam int MODE_RANDOM   = 0;
    localparam int MODE_FILL     = 1;
    localparam int MODE_FLUSH    = 2;
    localparam int MODE_IDLE     = 3;

    typedef struct packed {
        logic [`ARCH_REG_BITS-1:0] rd;
        phys_tag_t                 pd;
    } tag_rec_t;

    logic      clk;
    logic      rst;
    logic      dispatch_valid;
    dispatch_t dispatch;
    logic      dispatch_ready;
    logic      out_valid;
    renamed_t  out;
    logic      out_ready;
    cdb_t      cdb [`CDB_PORTS];
    commit_t   commit;
    logic      flush;

    // shadow model of the rename state
    phys_tag_t             spec_map [`ARCH_REGS];
    phys_tag_t             com_map [`ARCH_REGS];
    logic [`ARCH_REGS-1:0] spec_rdy;
    phys_tag_t             free_q [$];
    phys_tag_t             hist_q [$];
    renamed_t              exp_q [$];
    tag_rec_t              rob_q [$];
    tag_rec_t              cdb_q [$];
    logic                  push_pend;
    phys_tag_t             push_tag;
    logic                  exp_valid;
    renamed_t              exp_head;
    int                    allocs;
    int                    errors;
    int                    seed;
    logic [31:0]           pc_next;

    rename_stage i_dut (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .dispatch_ready (dispatch_ready),
        .out_valid      (out_valid),
        .out            (out),
        .out_ready      (out_ready),
        .cdb            (cdb),
        .commit         (commit),
        .flush          (flush)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TOTAL_CYCLES * CLK_PERIOD * MARGIN);
        $display("watchdog expired before the test sequence finished");
        $display("Result: FAILED");
        $finish;
    end

    // {uses rs1, uses rs2, writes rd}
    function automatic logic [2:0] decode_uses(input logic [6:0] opc, input logic [4:0] rd);
        case (opc)
            op_lui, op_auipc, op_jal: decode_uses = {2'b00, rd != 5'd0};
            op_br, op_store:          decode_uses = 3'b110;
            op_reg:                   decode_uses = {2'b11, rd != 5'd0};
            default:                  decode_uses = {2'b10, rd != 5'd0};
        endcase
    endfunction

    function automatic dispatch_t make_dispatch(input logic fill);
        logic [31:0] rnd;
        logic [31:0] fld;
        logic [6:0]  opc;
        dispatch_t   d;
        rnd = $random(seed);
        fld = $random(seed);
        case (rnd % 32'd9)
            0:       opc = op_lui;
            1:       opc = op_auipc;
            2:       opc = op_jal;
            3:       opc = op_jalr;
            4:       opc = op_br;
            5:       opc = op_load;
            6:       opc = op_store;
            7:       opc = op_imm;
            default: opc = op_reg;
        endcase
        // x0 shows up more often than chance
        if (fld[1:0] == 2'b00) fld[19:15] = 5'd0;
        if (fld[3:2] == 2'b00) fld[24:20] = 5'd0;
        if (fld[6:4] == 3'b000) fld[11:7] = 5'd0;
        if (fill) begin
            opc = op_imm;
            if (fld[11:7] == 5'd0) fld[11:7] = 5'd1;
        end
        d.inst = {fld[31:7], opc};
        d.pc   = pc_next;
        pc_next = pc_next + 32'd4;
        return d;
    endfunction

    task automatic drive_cycle(input int mode);
        logic [31:0] rnd;
        int          idx;
        tag_rec_t    r;
        rnd = $random(seed);
        flush = (mode == MODE_FLUSH) || (mode == MODE_RANDOM && rnd[5:0] == 6'd0);
        dispatch_valid = (mode == MODE_FILL) || (mode != MODE_IDLE && rnd[7:6] != 2'b00);
        dispatch = make_dispatch(mode == MODE_FILL);
        out_ready = (mode != MODE_RANDOM) || rnd[9:8] != 2'b00;
        commit = '0;
        // results return out of order and sometimes after a rename of the same rd
        for (int p = 0; p < `CDB_PORTS; p++) begin
            cdb[p] = '0;
            rnd = $random(seed);
            if (mode == MODE_RANDOM && cdb_q.size() != 0 && rnd[1:0] == 2'b00) begin
                idx = int'(rnd[31:8] % cdb_q.size());
                r = cdb_q[idx];
                cdb_q.delete(idx);
                cdb[p].valid = 1'b1;
                cdb[p].rd    = r.rd;
                cdb[p].pd    = r.pd;
            end
        end
        rnd = $random(seed);
        if (mode == MODE_RANDOM && !flush && rob_q.size() > 2 && rnd[0]) begin
            r = rob_q.pop_front();
            commit.valid = 1'b1;
            commit.rd    = r.rd;
            commit.pd    = r.pd;
        end
    endtask

    // applies the coming clock edge to the shadow model
    task automatic model_edge();
        rv_inst_u   inst;
        logic [2:0] uses;
        logic       acc;
        logic       exp_rdy;
        renamed_t   e;
        tag_rec_t   r;
        inst = dispatch.inst;
        uses = decode_uses(inst.r.opcode, inst.r.rd);
        exp_rdy = (!exp_valid || out_ready) && (free_q.size() != 0 || !uses[0]) && !flush;
        acc  = dispatch_valid && exp_rdy;
        a_ready: assert (dispatch_ready == exp_rdy) else begin
            errors++;
            $display("MISMATCH dispatch_ready got 0x%h exp 0x%h", dispatch_ready, exp_rdy);
        end
        // transfers that the DUT takes with a destination
        if (dispatch_valid && dispatch_ready && uses[0]) allocs++;
        if (exp_valid && out_ready) void'(exp_q.pop_front());
        if (acc) begin
            e.inst      = inst;
            e.pc        = dispatch.pc;
            e.ps1       = uses[2] ? spec_map[inst.r.rs1] : '0;
            e.ps2       = uses[1] ? spec_map[inst.r.rs2] : '0;
            e.ps1_ready = uses[2] ? spec_rdy[inst.r.rs1] : 1'b1;
            e.ps2_ready = uses[1] ? spec_rdy[inst.r.rs2] : 1'b1;
            e.has_rd    = uses[0];
            e.rd        = inst.r.rd;
            e.pd        = '0;
            if (uses[0] && free_q.size() != 0) begin
                e.pd = free_q.pop_front();
                r.rd = inst.r.rd;
                r.pd = e.pd;
                rob_q.push_back(r);
                cdb_q.push_back(r);
            end
            exp_q.push_back(e);
        end
        // wakeup compares against the mapping before this edge
        for (int p = 0; p < `CDB_PORTS; p++) begin
            if (cdb[p].valid && cdb[p].pd == spec_map[cdb[p].rd]) spec_rdy[cdb[p].rd] = 1'b1;
        end
        if (acc && uses[0]) begin
            spec_map[inst.r.rd] = e.pd;
            spec_rdy[inst.r.rd] = 1'b0;
        end
        spec_rdy[0] = 1'b1;
        // stale tag of last cycle's commit enters the queue now
        if (push_pend) begin
            free_q.push_back(push_tag);
            hist_q.push_back(push_tag);
            if (hist_q.size() > `FREE_REGS) void'(hist_q.pop_front());
        end
        push_pend = commit.valid;
        if (commit.valid) begin
            push_tag = com_map[commit.rd];
            com_map[commit.rd] = commit.pd;
        end
        if (flush) begin
            spec_map = com_map;
            spec_rdy = '1;
            free_q   = hist_q;
            exp_q.delete();
            rob_q.delete();
            cdb_q.delete();
        end
        exp_valid = exp_q.size() != 0;
        if (exp_valid) exp_head = exp_q[0];
    endtask

    task automatic run_cycles(input int mode, input int n);
        repeat (n) begin
            @(negedge clk);
            drive_cycle(mode);
            #1;
            model_edge();
        end
    endtask

    // output register against the model head
    a_out_valid: assert property (@(negedge clk) disable iff (rst) out_valid == exp_valid)
    else begin
        errors++;
        $display("MISMATCH out_valid got 0x%h exp 0x%h", out_valid, exp_valid);
    end

    a_out_data: assert property (@(negedge clk) disable iff (rst) out_valid |-> out == exp_head)
    else begin
        errors++;
        $display("MISMATCH out got 0x%h exp 0x%h", out, exp_head);
    end

    initial begin
        seed           = 89;
        errors         = 0;
        allocs         = 0;
        pc_next        = 32'h0000_1000;
        rst            = 1'b1;
        flush          = 1'b0;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        out_ready      = 1'b0;
        commit         = '0;
        for (int p = 0; p < `CDB_PORTS; p++) cdb[p] = '0;
        for (int i = 0; i < `ARCH_REGS; i++) begin
            spec_map[i] = phys_tag_t'(i);
            com_map[i]  = phys_tag_t'(i);
            free_q.push_back(phys_tag_t'(`ARCH_REGS + i));
            hist_q.push_back(phys_tag_t'(`ARCH_REGS + i));
        end
        spec_rdy  = '1;
        push_pend = 1'b0;
        push_tag  = '0;
        exp_valid = 1'b0;
        exp_head  = '0;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        run_cycles(MODE_RANDOM, RANDOM_CYCLES);
        // fill from a freshly restored free list
        run_cycles(MODE_FLUSH, 1);
        allocs = 0;
        run_cycles(MODE_FILL, FILL_CYCLES);
        a_fill_count: assert (allocs == `FREE_REGS) else begin
            errors++;
            $display("MISMATCH allocations before stall got 0x%h exp 0x%h", allocs, `FREE_REGS);
        end
        run_cycles(MODE_FLUSH, 1);
        run_cycles(MODE_RANDOM, RANDOM_CYCLES);
        run_cycles(MODE_IDLE, IDLE_CYCLES);

        $display("rename checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+verilog
verilog/rv32i_pkg.sv
verilog/rename_pkg.sv
verilog/rat.sv
verilog/rrat.sv
verilog/free_list.sv
verilog/rename_stage.sv
dv/rename_tb.sv

// File: run.sh
#!/bin/sh
# build and run the rename stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f all.f --top-module rename_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vrename_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Result: PASSED"; then
    exit 0
fi
exit 1
